// File: design/rx_word_pkg.sv
package rx_word_pkg;

	// ==============================
	// packet word geometry
	// ==============================

	localparam int BYTE_W = 8;
	localparam int LANES = 16;
	localparam int LANE_W = 4;
	localparam int TAG_W = 2;
	localparam int UNUSED_W = 4;
	localparam int DATA_W = BYTE_W * LANES;

	// tag on top, then unused count, then the 16 data lanes
	localparam int WORD_W = TAG_W + UNUSED_W + DATA_W;

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [LANE_W-1:0] lane_t;
	typedef logic [UNUSED_W-1:0] unused_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [WORD_W-1:0] word_t;

	// last lane of a word, lane 0 is the top byte
	localparam lane_t LANE_LAST = lane_t'(LANES - 1);

	// ==============================
	// position tags
	// ==============================

	// first word of a frame that goes on
	localparam tag_t TAG_FIRST = 2'b01;
	// word inside a frame
	localparam tag_t TAG_MIDDLE = 2'b11;
	// closing word, unused count is valid here
	localparam tag_t TAG_LAST = 2'b10;

endpackage

// File: design/rx_mac_pkg.sv
package rx_mac_pkg;

	// ==============================
	// MAC receive side
	// ==============================

	localparam int ERR_W = 6;

	// per-frame error vector, sampled with the end byte
	typedef logic [ERR_W-1:0] rx_err_t;

	// clean frame
	localparam rx_err_t ERR_NONE = '0;

	// ==============================
	// frame admission FSM
	// ==============================

	// pass takes bytes into the packer
	// drop swallows a refused frame up to its end byte
	typedef enum logic [1:0] {
		FRAME_PASS = 2'b00,
		FRAME_DROP = 2'b01
	} frame_state_e;

endpackage

// File: design/rx_frame_ctrl.sv
`timescale 1ns/1ns

module rx_frame_ctrl (
	input  logic                ff_rx_clk,
	input  logic                reset,

	// MAC byte stream flags
	input  logic                ff_rx_sop,
	input  logic                ff_rx_eop,
	input  logic                ff_rx_dval,
	input  rx_mac_pkg::rx_err_t rx_err,

	// FIFO fill level
	input  logic                out_pkt_almostfull,

	// from the packer, lane counter at 0
	input  logic                word_open,

	// to the packer, same cycle as the byte
	output logic                byte_take,
	output logic                frame_start,
	output logic                frame_end,

	// registered outputs
	output logic                ff_rx_rdy,
	output logic                pkt_receive_add,
	output logic                pkt_discard_add,
	output logic                out_valid_wrreq,
	output logic                out_valid
);

	rx_mac_pkg::frame_state_e state_q;

	logic in_pass;
	logic sop_seen;
	logic start_ok;
	logic start_refused;

	// ==============================
	// admission decode
	// ==============================

	assign in_pass = (state_q == rx_mac_pkg::FRAME_PASS);

	// sop only counts at a word boundary
	assign sop_seen = ff_rx_dval && ff_rx_sop && word_open && in_pass;

	// almost-full is looked at only here, a running frame is never cut
	assign start_ok = sop_seen && !out_pkt_almostfull;
	assign start_refused = sop_seen && out_pkt_almostfull;

	// every valid byte in pass, except a refused start
	assign byte_take = ff_rx_dval && in_pass && !start_refused;

	assign frame_start = start_ok;

	// start beats end when one byte carries both
	assign frame_end = byte_take && ff_rx_eop && !start_ok;

	// ==============================
	// state and registered outputs
	// ==============================

	always_ff @(posedge ff_rx_clk or negedge reset) begin
		if (!reset) begin
			state_q <= rx_mac_pkg::FRAME_PASS;
		end else begin
			case (state_q)
				rx_mac_pkg::FRAME_PASS: begin
					if (start_refused) begin
						state_q <= rx_mac_pkg::FRAME_DROP;
					end
				end
				rx_mac_pkg::FRAME_DROP: begin
					// swallow until the refused frame ends
					if (ff_rx_dval && ff_rx_eop) begin
						state_q <= rx_mac_pkg::FRAME_PASS;
					end
				end
				default: begin
					state_q <= rx_mac_pkg::FRAME_PASS;
				end
			endcase
		end
	end

	// statistic pulses on the start byte
	always_ff @(posedge ff_rx_clk or negedge reset) begin
		if (!reset) begin
			pkt_receive_add <= 1'b0;
			pkt_discard_add <= 1'b0;
		end else begin
			pkt_receive_add <= start_ok;
			pkt_discard_add <= start_refused;
		end
	end

	// verdict goes out with the last word
	always_ff @(posedge ff_rx_clk or negedge reset) begin
		if (!reset) begin
			out_valid_wrreq <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			out_valid_wrreq <= frame_end;
			out_valid <= frame_end && (rx_err == rx_mac_pkg::ERR_NONE);
		end
	end

	// ready rises on the first clock out of reset and stays
	always_ff @(posedge ff_rx_clk or negedge reset) begin
		if (!reset) begin
			ff_rx_rdy <= 1'b0;
		end else begin
			ff_rx_rdy <= 1'b1;
		end
	end

endmodule

// File: design/rx_word_packer.sv
`timescale 1ns/1ns

module rx_word_packer (
	input  logic                 ff_rx_clk,
	input  logic                 reset,

	// byte and qualifiers from the control block
	input  rx_word_pkg::byte_t   ff_rx_data,
	input  logic                 byte_take,
	input  logic                 frame_start,
	input  logic                 frame_end,

	// lane counter sits at 0
	output logic                 word_open,

	// FIFO write side
	output logic                 out_pkt_wrreq,
	output rx_word_pkg::word_t   out_pkt
);

	rx_word_pkg::lane_t lane_q;
	rx_word_pkg::lane_t lane_rev;
	rx_word_pkg::tag_t tag_q;
	rx_word_pkg::unused_t unused_q;
	rx_word_pkg::data_t data_q;

	logic word_done;

	// ==============================
	// lane decode
	// ==============================

	assign word_open = (lane_q == '0);

	// lane 0 is the top byte, big-endian order
	// distance to the bottom lane is also the unused count
	assign lane_rev = rx_word_pkg::LANE_LAST - lane_q;

	// word closes on the end byte or on a full word
	assign word_done = byte_take && (frame_end || (lane_q == rx_word_pkg::LANE_LAST));

	// ==============================
	// lane counter
	// ==============================

	// idle cycles leave the counter where it is
	always_ff @(posedge ff_rx_clk or negedge reset) begin
		if (!reset) begin
			lane_q <= '0;
		end else if (byte_take) begin
			if (word_done) begin
				lane_q <= '0;
			end else begin
				lane_q <= lane_q + 1'b1;
			end
		end
	end

	// ==============================
	// byte placement
	// ==============================

	// lanes past the last byte keep whatever was there
	always_ff @(posedge ff_rx_clk or negedge reset) begin
		if (!reset) begin
			data_q <= '0;
		end else if (byte_take) begin
			data_q[lane_rev * rx_word_pkg::BYTE_W +: rx_word_pkg::BYTE_W] <= ff_rx_data;
		end
	end

	// ==============================
	// tag and unused count
	// ==============================

	always_ff @(posedge ff_rx_clk or negedge reset) begin
		if (!reset) begin
			tag_q <= '0;
			unused_q <= '0;
		end else if (byte_take) begin
			if (frame_end) begin
				// end can land on any lane, lane 0 included
				tag_q <= rx_word_pkg::TAG_LAST;
				unused_q <= rx_word_pkg::unused_t'(lane_rev);
			end else if (word_open) begin
				if (frame_start) begin
					tag_q <= rx_word_pkg::TAG_FIRST;
				end else begin
					tag_q <= rx_word_pkg::TAG_MIDDLE;
				end
				// a word that is not last is full
				unused_q <= '0;
			end
		end
	end

	// ==============================
	// write strobe
	// ==============================

	// same edge as the closing byte lands in data_q
	always_ff @(posedge ff_rx_clk or negedge reset) begin
		if (!reset) begin
			out_pkt_wrreq <= 1'b0;
		end else begin
			out_pkt_wrreq <= word_done;
		end
	end

	assign out_pkt = {tag_q, unused_q, data_q};

endmodule

// File: design/sgmii_rx_top.sv
`timescale 1ns/1ns

module sgmii_rx_top (
	input  logic                ff_rx_clk,
	input  logic                reset,

	// MAC receive stream
	input  rx_word_pkg::byte_t  ff_rx_data,
	input  logic                ff_rx_sop,
	input  logic                ff_rx_eop,
	input  logic                ff_rx_dval,
	input  rx_mac_pkg::rx_err_t rx_err,
	output logic                ff_rx_rdy,

	// statistics
	output logic                pkt_receive_add,
	output logic                pkt_discard_add,

	// packet FIFO
	output logic                out_pkt_wrreq,
	output rx_word_pkg::word_t  out_pkt,
	input  logic                out_pkt_almostfull,

	// verdict FIFO
	output logic                out_valid_wrreq,
	output logic                out_valid
);

	// ==============================
	// control to packer
	// ==============================

	logic byte_take;
	logic frame_start;
	logic frame_end;
	logic word_open;

	// admission, verdict, statistics and ready
	rx_frame_ctrl u_frame_ctrl (
		.ff_rx_clk          (ff_rx_clk),
		.reset              (reset),
		.ff_rx_sop          (ff_rx_sop),
		.ff_rx_eop          (ff_rx_eop),
		.ff_rx_dval         (ff_rx_dval),
		.rx_err             (rx_err),
		.out_pkt_almostfull (out_pkt_almostfull),
		.word_open          (word_open),
		.byte_take          (byte_take),
		.frame_start        (frame_start),
		.frame_end          (frame_end),
		.ff_rx_rdy          (ff_rx_rdy),
		.pkt_receive_add    (pkt_receive_add),
		.pkt_discard_add    (pkt_discard_add),
		.out_valid_wrreq    (out_valid_wrreq),
		.out_valid          (out_valid)
	);

	// 16 bytes per word plus tag and unused count
	rx_word_packer u_word_packer (
		.ff_rx_clk     (ff_rx_clk),
		.reset         (reset),
		.ff_rx_data    (ff_rx_data),
		.byte_take     (byte_take),
		.frame_start   (frame_start),
		.frame_end     (frame_end),
		.word_open     (word_open),
		.out_pkt_wrreq (out_pkt_wrreq),
		.out_pkt       (out_pkt)
	);

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
	output logic ff_rx_clk,
	output logic reset
);

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 4;

	initial begin
		ff_rx_clk = 1'b0;
		forever #HALF_PERIOD ff_rx_clk = ~ff_rx_clk;
	end

	// release away from both edges
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge ff_rx_clk);
		#(HALF_PERIOD / 2) reset = 1'b1;
	end

endmodule

// File: sim/tb_sgmii_rx.sv
`timescale 1ns/1ns

module tb_sgmii_rx;

	localparam int ROWS = 12;
	localparam int WAIT_LIMIT = 200;

	logic ff_rx_clk;
	logic reset;
	logic [7:0] ff_rx_data;
	logic ff_rx_sop;
	logic ff_rx_eop;
	logic ff_rx_dval;
	rx_mac_pkg::rx_err_t rx_err;
	logic ff_rx_rdy;
	logic pkt_receive_add;
	logic pkt_discard_add;
	logic out_pkt_wrreq;
	rx_word_pkg::word_t out_pkt;
	logic out_pkt_almostfull;
	logic out_valid_wrreq;
	logic out_valid;

	// each row packs length, error vector, almost-full at sop and gap flag
	logic [15:0] frame_tab [0:ROWS-1];
	logic [31:0] lcg_state;
	logic [7:0] frame_bytes [$];
	rx_word_pkg::word_t exp_words [$];
	rx_word_pkg::word_t exp_masks [$];
	rx_word_pkg::word_t got_words [$];
	logic got_valid [$];
	logic got_with_word [$];
	int receive_count;
	int discard_count;
	int word_errs;
	int flag_errs;
	int count_errs;
	int timeout_errs;

	tb_clock_gen u_clock_gen (
		.ff_rx_clk (ff_rx_clk),
		.reset     (reset)
	);

	sgmii_rx_top u_dut (
		.ff_rx_clk          (ff_rx_clk),
		.reset              (reset),
		.ff_rx_data         (ff_rx_data),
		.ff_rx_sop          (ff_rx_sop),
		.ff_rx_eop          (ff_rx_eop),
		.ff_rx_dval         (ff_rx_dval),
		.rx_err             (rx_err),
		.ff_rx_rdy          (ff_rx_rdy),
		.pkt_receive_add    (pkt_receive_add),
		.pkt_discard_add    (pkt_discard_add),
		.out_pkt_wrreq      (out_pkt_wrreq),
		.out_pkt            (out_pkt),
		.out_pkt_almostfull (out_pkt_almostfull),
		.out_valid_wrreq    (out_valid_wrreq),
		.out_valid          (out_valid)
	);

	// ==============================
	// helpers
	// ==============================

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic check_word(input string name, input rx_word_pkg::word_t got,
			input rx_word_pkg::word_t exp, input rx_word_pkg::word_t mask);
		if ((got & mask) !== (exp & mask)) begin
			word_errs++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got & mask, exp & mask);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			flag_errs++;
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			count_errs++;
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic load_table();
		frame_tab[0] = {8'd2, 6'h00, 1'b0, 1'b0};
		frame_tab[1] = {8'd16, 6'h00, 1'b0, 1'b0};
		frame_tab[2] = {8'd9, 6'h04, 1'b0, 1'b1};
		frame_tab[3] = {8'd17, 6'h00, 1'b0, 1'b0};
		frame_tab[4] = {8'd40, 6'h21, 1'b0, 1'b1};
		frame_tab[5] = {8'd24, 6'h00, 1'b1, 1'b0};
		frame_tab[6] = {8'd33, 6'h00, 1'b0, 1'b0};
		frame_tab[7] = {8'd64, 6'h00, 1'b0, 1'b1};
		frame_tab[8] = {8'd70, 6'h3f, 1'b0, 1'b0};
		frame_tab[9] = {8'd12, 6'h00, 1'b1, 1'b1};
		frame_tab[10] = {8'd48, 6'h00, 1'b0, 1'b1};
		frame_tab[11] = {8'd5, 6'h01, 1'b0, 1'b0};
	endtask

	// reference words with the first byte in the top lane
	task automatic build_expected(input int len);
		rx_word_pkg::word_t w;
		rx_word_pkg::word_t m;
		rx_word_pkg::tag_t tag;
		rx_word_pkg::unused_t unused;
		int nw;
		int k;
		int lane;
		exp_words.delete();
		exp_masks.delete();
		nw = (len + 15) / 16;
		for (k = 0; k < nw; k++) begin
			unused = '0;
			if (k == nw - 1) begin
				tag = 2'b10;
				unused = rx_word_pkg::unused_t'(16 - ((len - 1) % 16 + 1));
			end else if (k == 0) begin
				tag = 2'b01;
			end else begin
				tag = 2'b11;
			end
			w = {tag, unused, 128'b0};
			m = {6'b111111, 128'b0};
			for (lane = 0; lane < 16 && k * 16 + lane < len; lane++) begin
				w[127 - lane * 8 -: 8] = frame_bytes[k * 16 + lane];
				m[127 - lane * 8 -: 8] = 8'hff;
			end
			exp_words.push_back(w);
			exp_masks.push_back(m);
		end
	endtask

	task automatic send_frame(input int len, input rx_mac_pkg::rx_err_t err,
			input logic afull, input logic gap);
		int i;
		int idle;
		for (i = 0; i < len; i++) begin
			if (gap && i > 0 && lcg_next() < 8'd80) begin
				idle = 1 + lcg_next() % 3;
				repeat (idle) begin
					@(negedge ff_rx_clk);
					ff_rx_dval = 1'b0;
					ff_rx_sop = 1'b0;
					ff_rx_eop = 1'b0;
					out_pkt_almostfull = 1'b0;
				end
			end
			@(negedge ff_rx_clk);
			ff_rx_dval = 1'b1;
			ff_rx_data = frame_bytes[i];
			ff_rx_sop = (i == 0);
			ff_rx_eop = (i == len - 1);
			rx_err = err;
			// almost-full after the start byte must not cut an admitted frame
			out_pkt_almostfull = (i == 0) ? afull : 1'b1;
		end
		@(negedge ff_rx_clk);
		ff_rx_dval = 1'b0;
		ff_rx_sop = 1'b0;
		ff_rx_eop = 1'b0;
		out_pkt_almostfull = 1'b0;
	endtask

	task automatic reset_phase();
		int n;
		// first rising edge loads the reset values
		@(posedge ff_rx_clk);
		@(negedge ff_rx_clk);
		check_flag("ff_rx_rdy", ff_rx_rdy, 1'b0);
		check_flag("out_pkt_wrreq", out_pkt_wrreq, 1'b0);
		check_flag("out_valid_wrreq", out_valid_wrreq, 1'b0);
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("pkt_receive_add", pkt_receive_add, 1'b0);
		check_flag("pkt_discard_add", pkt_discard_add, 1'b0);
		check_word("out_pkt", out_pkt, '0, '1);
		n = 0;
		while (reset !== 1'b1 && n < WAIT_LIMIT) begin
			@(negedge ff_rx_clk);
			n++;
		end
		if (reset !== 1'b1) begin
			timeout_errs++;
			$display("timeout: reset was never released");
		end
		@(negedge ff_rx_clk);
		check_flag("ff_rx_rdy", ff_rx_rdy, 1'b1);
		@(posedge ff_rx_clk);
	endtask

	// ==============================
	// one table row
	// ==============================

	task automatic run_row(input int r);
		int len;
		rx_mac_pkg::rx_err_t err;
		logic afull;
		logic gap;
		int rx_before;
		int dc_before;
		int nw;
		int n;
		int k;
		len = frame_tab[r][15:8];
		err = frame_tab[r][7:2];
		afull = frame_tab[r][1];
		gap = frame_tab[r][0];
		frame_bytes.delete();
		for (k = 0; k < len; k++) begin
			frame_bytes.push_back(lcg_next());
		end
		build_expected(len);
		nw = exp_words.size();
		got_words.delete();
		got_valid.delete();
		got_with_word.delete();
		rx_before = receive_count;
		dc_before = discard_count;
		send_frame(len, err, afull, gap);
		if (!afull) begin
			n = 0;
			while ((got_words.size() < nw || got_valid.size() < 1) && n < WAIT_LIMIT) begin
				@(posedge ff_rx_clk);
				n++;
			end
			if (got_words.size() < nw || got_valid.size() < 1) begin
				timeout_errs++;
				$display("timeout: row %0d got %0d of %0d words and %0d verdicts",
					r, got_words.size(), nw, got_valid.size());
			end
			repeat (2) @(posedge ff_rx_clk);
			check_count($sformatf("out_pkt_wrreq count row %0d", r), got_words.size(), nw);
			check_count($sformatf("out_valid_wrreq count row %0d", r), got_valid.size(), 1);
			for (k = 0; k < nw && k < got_words.size(); k++) begin
				check_word($sformatf("out_pkt row %0d word %0d", r, k),
					got_words[k], exp_words[k], exp_masks[k]);
			end
			if (got_valid.size() > 0) begin
				check_flag($sformatf("out_valid row %0d", r), got_valid[0], (err == '0));
				check_flag($sformatf("out_pkt_wrreq with verdict row %0d", r),
					got_with_word[0], 1'b1);
			end
			check_count($sformatf("pkt_receive_add row %0d", r), receive_count - rx_before, 1);
			check_count($sformatf("pkt_discard_add row %0d", r), discard_count - dc_before, 0);
		end else begin
			n = 0;
			while (discard_count == dc_before && n < WAIT_LIMIT) begin
				@(posedge ff_rx_clk);
				n++;
			end
			if (discard_count == dc_before) begin
				timeout_errs++;
				$display("timeout: row %0d never pulsed pkt_discard_add", r);
			end
			repeat (2) @(posedge ff_rx_clk);
			check_count($sformatf("out_pkt_wrreq count row %0d", r), got_words.size(), 0);
			check_count($sformatf("out_valid_wrreq count row %0d", r), got_valid.size(), 0);
			check_count($sformatf("pkt_receive_add row %0d", r), receive_count - rx_before, 0);
			check_count($sformatf("pkt_discard_add row %0d", r), discard_count - dc_before, 1);
		end
	endtask

	// outputs settle on the rising edge and are sampled half a period later
	always @(negedge ff_rx_clk) begin
		if (reset) begin
			if (out_pkt_wrreq) begin
				got_words.push_back(out_pkt);
			end
			if (out_valid_wrreq) begin
				got_valid.push_back(out_valid);
				got_with_word.push_back(out_pkt_wrreq);
			end
			if (pkt_receive_add) begin
				receive_count++;
			end
			if (pkt_discard_add) begin
				discard_count++;
			end
		end
	end

	// ==============================
	// main sequence
	// ==============================

	initial begin
		int r;
		int admitted;
		int refused;
		int total;
		ff_rx_data = '0;
		ff_rx_sop = 1'b0;
		ff_rx_eop = 1'b0;
		ff_rx_dval = 1'b0;
		rx_err = '0;
		out_pkt_almostfull = 1'b0;
		lcg_state = 32'd24748;
		receive_count = 0;
		discard_count = 0;
		word_errs = 0;
		flag_errs = 0;
		count_errs = 0;
		timeout_errs = 0;
		admitted = 0;
		refused = 0;
		load_table();
		reset_phase();
		for (r = 0; r < ROWS; r++) begin
			if (frame_tab[r][1]) begin
				refused++;
			end else begin
				admitted++;
			end
			run_row(r);
		end
		check_count("pkt_receive_add total", receive_count, admitted);
		check_count("pkt_discard_add total", discard_count, refused);
		total = word_errs + flag_errs + count_errs + timeout_errs;
		$display("errors: word %0d flag %0d count %0d timeout %0d",
			word_errs, flag_errs, count_errs, timeout_errs);
		if (total == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
design/rx_word_pkg.sv
design/rx_mac_pkg.sv
design/rx_frame_ctrl.sv
design/rx_word_packer.sv
design/sgmii_rx_top.sv
sim/tb_clock_gen.sv
sim/tb_sgmii_rx.sv

// File: Bender.yml
package:
  name: sgmii_rx

sources:
  # design sources, packages first
  - files:
      - design/rx_word_pkg.sv
      - design/rx_mac_pkg.sv
      - design/rx_frame_ctrl.sv
      - design/rx_word_packer.sv
      - design/sgmii_rx_top.sv

  # testbench sources
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_sgmii_rx.sv
